/* source/exec_consts.svh */
`ifndef EXEC_CONSTS_SVH
`define EXEC_CONSTS_SVH

// most significant bit of an 80 bit data word
`define DMSB            79

// ==========================================================
// instruction field positions within the 40 bit word
// ==========================================================
`define OPCODE_FIELD    5:0
`define AMOUNT_FIELD    24:18
`define FUNCT_FIELD     39:35

// register-register class, the only class this stage executes
`define OP_R1           6'h02

// shift and rotate functions, amount taken from b
`define SHL             5'h00
`define ASL             5'h01
`define SHR             5'h02
`define ASR             5'h03
`define ROL             5'h04
`define ROR             5'h05
// the same functions with the amount taken from the instruction
`define SHLI            5'h08
`define ASLI            5'h09
`define SHRI            5'h0A
`define ASRI            5'h0B
`define ROLI            5'h0C
`define RORI            5'h0D

// add and logic functions
`define ADD             5'h10
`define SUB             5'h11
`define AND             5'h12
`define OR              5'h13
`define XOR             5'h14

// value returned by a rotate while rotates are switched off
`define MARKER          80'hDEADDEADDEADDEAD

`endif

/* source/execPkg.sv */
`include "exec_consts.svh"

package execPkg;

    // ==========================================================
    // decoded operations
    // ==========================================================

    // the six shift kinds sit together so the top level can
    // route them to the shifter as one group
    typedef enum logic [3:0] {
        opNone = 4'd0,
        opShl  = 4'd1,
        opAsl  = 4'd2,
        opShr  = 4'd3,
        opAsr  = 4'd4,
        opRol  = 4'd5,
        opRor  = 4'd6,
        // add and logic group
        opAdd  = 4'd7,
        opSub  = 4'd8,
        opAnd  = 4'd9,
        opOr   = 4'd10,
        opXor  = 4'd11
    } execOp_t;

    // ==========================================================
    // stage payloads
    // ==========================================================

    // one decoded instruction as it enters the first register
    // stage, the second operand is already the immediate when
    // the function is an immediate form
    typedef struct packed {
        execOp_t         op;
        logic [`DMSB:0]  a;
        logic [`DMSB:0]  b;
        logic            valid;
    } execRequest_t;

    // one finished result as it enters the second register stage
    // ov carries the overflow of whichever unit produced res
    typedef struct packed {
        logic [`DMSB:0]  res;
        logic            ov;
        logic            valid;
    } execResult_t;

endpackage

/* source/instrDecode.sv */
`include "exec_consts.svh"

module instrDecode (
    input  logic                  issue,
    input  logic [39:0]           instr,
    input  logic [`DMSB:0]        a,
    input  logic [`DMSB:0]        b,
    output execPkg::execRequest_t request
);
    import execPkg::*;

    // raw fields of the instruction word
    logic [5:0] opcode;
    logic [4:0] funct;
    logic [6:0] amount;

    // decoded operation and immediate select
    execOp_t    op;
    logic       useImmediate;

    assign opcode = instr[`OPCODE_FIELD];
    assign funct  = instr[`FUNCT_FIELD];
    assign amount = instr[`AMOUNT_FIELD];

    // ==========================================================
    // opcode and function decode
    // ==========================================================

    // anything outside the register class, or a function code
    // that is not listed, decodes to opNone and so yields zero
    always_comb begin
        op           = opNone;
        useImmediate = 1'b0;
        if (opcode == `OP_R1) begin
            case (funct)
                `SHL:  op = opShl;
                `ASL:  op = opAsl;
                `SHR:  op = opShr;
                `ASR:  op = opAsr;
                `ROL:  op = opRol;
                `ROR:  op = opRor;
                `ADD:  op = opAdd;
                `SUB:  op = opSub;
                `AND:  op = opAnd;
                `OR:   op = opOr;
                `XOR:  op = opXor;
                // immediate forms share the shift kinds but swap
                // in the amount field for the second operand
                `SHLI: begin
                    op           = opShl;
                    useImmediate = 1'b1;
                end
                `ASLI: begin
                    op           = opAsl;
                    useImmediate = 1'b1;
                end
                `SHRI: begin
                    op           = opShr;
                    useImmediate = 1'b1;
                end
                `ASRI: begin
                    op           = opAsr;
                    useImmediate = 1'b1;
                end
                `ROLI: begin
                    op           = opRol;
                    useImmediate = 1'b1;
                end
                `RORI: begin
                    op           = opRor;
                    useImmediate = 1'b1;
                end
                default: op = opNone;
            endcase
        end
    end

    // ==========================================================
    // request assembly
    // ==========================================================

    // the amount field is zero extended to a full data word
    assign request.op    = op;
    assign request.a     = a;
    assign request.b     = useImmediate ? {{(`DMSB - 6){1'b0}}, amount} : b;
    assign request.valid = issue;

endmodule

/* source/shifter.sv */
`include "exec_consts.svh"

module shifter (
    input  execPkg::execOp_t op,
    input  logic [`DMSB:0]   a,
    input  logic [`DMSB:0]   b,
    input  logic             rotateEnable,
    output logic [`DMSB:0]   res,
    output logic             ov
);
    import execPkg::*;

    // only the low seven bits of b count, so amounts run 0 to 127
    logic [6:0]            amount;

    // double width shifts, the data sits in the low word for the
    // left shift and in the high word for the right shift
    logic [2*`DMSB+1:0]    shl;
    logic [2*`DMSB+1:0]    shr;

    // word halves of the two shifts
    logic [`DMSB:0]        shlLow;
    logic [`DMSB:0]        shlHigh;
    logic [`DMSB:0]        shrLow;
    logic [`DMSB:0]        shrHigh;

    // ones in the top amount positions, all ones from 80 upward
    logic [`DMSB:0]        topMask;
    logic [`DMSB:0]        signWord;

    assign amount = b[6:0];

    assign shl = {{(`DMSB + 1){1'b0}}, a} << amount;
    assign shr = {a, {(`DMSB + 1){1'b0}}} >> amount;

    assign shlLow  = shl[`DMSB:0];
    assign shlHigh = shl[2*`DMSB+1:`DMSB+1];
    assign shrLow  = shr[`DMSB:0];
    assign shrHigh = shr[2*`DMSB+1:`DMSB+1];

    assign topMask  = ~({(`DMSB + 1){1'b1}} >> amount);
    assign signWord = {(`DMSB + 1){a[`DMSB]}};

    // ==========================================================
    // result select
    // ==========================================================

    // a rotate is the OR of the two halves of one double width shift
    // which only holds for amounts below 80, larger amounts give
    // the plain shifted upper word as the original block did
    always_comb begin
        case (op)
            opShl, opAsl: res = shlLow;
            opShr:        res = shrHigh;
            // fill the vacated top bits with the sign
            opAsr:        res = shrHigh | (a[`DMSB] ? topMask : '0);
            opRol:        res = rotateEnable ? (shlLow | shlHigh) : `MARKER;
            opRor:        res = rotateEnable ? (shrLow | shrHigh) : `MARKER;
            default:      res = '0;
        endcase
    end

    // ==========================================================
    // left shift overflow
    // ==========================================================

    // the top amount bits of a are the ones pushed out of the word,
    // any of them that disagrees with the sign bit means the value
    // no longer fits
    assign ov = (op == opShl || op == opAsl) && |((a ^ signWord) & topMask);

endmodule

/* source/addLogicUnit.sv */
`include "exec_consts.svh"

module addLogicUnit (
    input  execPkg::execOp_t op,
    input  logic [`DMSB:0]   a,
    input  logic [`DMSB:0]   b,
    output logic [`DMSB:0]   res,
    output logic             ov
);
    import execPkg::*;

    // both arithmetic results are formed every cycle
    logic [`DMSB:0] sum;
    logic [`DMSB:0] diff;

    // signed overflow of each, taken from the sign bits only
    logic           sumOv;
    logic           diffOv;

    assign sum  = a + b;
    assign diff = a - b;

    // ==========================================================
    // signed overflow
    // ==========================================================

    // an add overflows when both inputs share a sign and the sum
    // comes out with the other one
    assign sumOv = (a[`DMSB] == b[`DMSB]) && (sum[`DMSB] != a[`DMSB]);

    // a subtract overflows when the inputs differ in sign and the
    // difference takes the sign of b
    assign diffOv = (a[`DMSB] != b[`DMSB]) && (diff[`DMSB] != a[`DMSB]);

    // ==========================================================
    // result select
    // ==========================================================

    // shift ops and opNone land in the default arm, so this unit
    // gives zero for them
    always_comb begin
        res = '0;
        ov  = 1'b0;
        case (op)
            opAdd: begin
                res = sum;
                ov  = sumOv;
            end
            opSub: begin
                res = diff;
                ov  = diffOv;
            end
            opAnd: res = a & b;
            opOr:  res = a | b;
            opXor: res = a ^ b;
            default: begin
                res = '0;
                ov  = 1'b0;
            end
        endcase
    end

endmodule

/* source/execConfig.sv */
module execConfig (
    input  logic                 clk,
    input  logic                 reset,
    input  logic                 cfgWrite,
    input  logic                 cfgRotateEnable,
    input  logic                 cfgClearOv,
    input  execPkg::execResult_t result,
    output logic                 rotateEnable,
    output logic                 ovSticky
);
    import execPkg::*;

    // a finished result that overflowed
    logic ovEvent;

    // request to drop the sticky flag
    logic ovClear;

    assign ovEvent = result.valid && result.ov;
    assign ovClear = cfgWrite && cfgClearOv;

    // ==========================================================
    // rotate enable
    // ==========================================================

    // every write loads the enable bit, including a write that is
    // only meant to clear the overflow flag
    // rotates come up enabled out of reset
    always_ff @(posedge clk) begin
        if (reset) begin
            rotateEnable <= 1'b1;
        end else if (cfgWrite) begin
            rotateEnable <= cfgRotateEnable;
        end
    end

    // ==========================================================
    // sticky overflow
    // ==========================================================

    // the flag follows the registered result, so it rises one cycle
    // after the done cycle that carried the overflow
    // a set in the same cycle as a clear takes priority so that no
    // overflow can slip past unrecorded
    always_ff @(posedge clk) begin
        if (reset) begin
            ovSticky <= 1'b0;
        end else if (ovEvent) begin
            ovSticky <= 1'b1;
        end else if (ovClear) begin
            ovSticky <= 1'b0;
        end
    end

endmodule

/* source/pipeStage.sv */
module pipeStage #(
    parameter type T = logic
) (
    input  logic clk,
    input  logic reset,
    input  T     d,
    output T     q
);

    // ==========================================================
    // stage register
    // ==========================================================

    // the whole payload clears on reset, not just its valid bit,
    // so a stage that has never been written reads as all zero
    // there is no enable and no stall, every edge loads d
    always_ff @(posedge clk) begin
        if (reset) begin
            q <= '0;
        end else begin
            q <= d;
        end
    end

endmodule

/* source/execUnit.sv */
`include "exec_consts.svh"

module execUnit (
    input  logic              clk,
    input  logic              reset,
    // instruction issue, one per cycle at most
    input  logic              issue,
    input  logic [39:0]       instr,
    input  logic [`DMSB:0]    a,
    input  logic [`DMSB:0]    b,
    // configuration write port
    input  logic              cfgWrite,
    input  logic              cfgRotateEnable,
    input  logic              cfgClearOv,
    // result two cycles after issue
    output logic              done,
    output logic [`DMSB:0]    res,
    output logic              ov,
    // configuration state
    output logic              rotateEnable,
    output logic              ovSticky
);
    import execPkg::*;

    // request before and after the first register
    execRequest_t decoded;
    execRequest_t issued;

    // outputs of the two units, both computed every cycle
    logic [`DMSB:0] shiftRes;
    logic           shiftOv;
    logic [`DMSB:0] aluRes;
    logic           aluOv;

    // result before and after the second register
    execResult_t    computed;
    execResult_t    retired;

    // the op is a shift or rotate
    logic           isShift;

    // ==========================================================
    // decode and first stage
    // ==========================================================

    instrDecode decodeI (
        .issue   (issue),
        .instr   (instr),
        .a       (a),
        .b       (b),
        .request (decoded)
    );

    pipeStage #(.T(execRequest_t)) requestStageI (
        .clk   (clk),
        .reset (reset),
        .d     (decoded),
        .q     (issued)
    );

    // ==========================================================
    // execute
    // ==========================================================

    shifter shifterI (
        .op           (issued.op),
        .a            (issued.a),
        .b            (issued.b),
        .rotateEnable (rotateEnable),
        .res          (shiftRes),
        .ov           (shiftOv)
    );

    addLogicUnit addLogicI (
        .op  (issued.op),
        .a   (issued.a),
        .b   (issued.b),
        .res (aluRes),
        .ov  (aluOv)
    );

    // opNone goes to the add/logic side, which returns zero for it
    assign isShift = issued.op inside {opShl, opAsl, opShr, opAsr, opRol, opRor};

    assign computed.res   = isShift ? shiftRes : aluRes;
    assign computed.ov    = isShift ? shiftOv : aluOv;
    assign computed.valid = issued.valid;

    // ==========================================================
    // result stage and configuration
    // ==========================================================

    pipeStage #(.T(execResult_t)) resultStageI (
        .clk   (clk),
        .reset (reset),
        .d     (computed),
        .q     (retired)
    );

    execConfig configI (
        .clk             (clk),
        .reset           (reset),
        .cfgWrite        (cfgWrite),
        .cfgRotateEnable (cfgRotateEnable),
        .cfgClearOv      (cfgClearOv),
        .result          (retired),
        .rotateEnable    (rotateEnable),
        .ovSticky        (ovSticky)
    );

    assign done = retired.valid;
    assign res  = retired.res;
    assign ov   = retired.ov;

endmodule

/* verification/execUnit_assertions.sv */
module execUnit_assertions (
    input logic clk,
    input logic reset,
    input logic issue,
    input logic cfgWrite,
    input logic cfgClearOv,
    input logic done,
    input logic ov,
    input logic rotateEnable,
    input logic ovSticky
);
    timeunit 1ns;
    timeprecision 1ps;

    // number of failed properties, looked at by the testbench when the run ends
    int violations = 0;

    // ==========================================================
    // latency
    // ==========================================================

    // an issue sampled at one edge retires at the second edge after it
    assert property (@(posedge clk) disable iff (reset) issue |-> ##2 done) else begin
        $error("an issued instruction did not retire two cycles later");
        violations++;
    end

    // and nothing retires that was not issued two edges earlier
    assert property (@(posedge clk) disable iff (reset) done |-> $past(issue, 2)) else begin
        $error("done rose without a matching issue");
        violations++;
    end

    // ==========================================================
    // reset state and sticky flag
    // ==========================================================

    assert property (@(posedge clk) reset |=> (!done && !ov && !ovSticky && rotateEnable))
    else begin
        $error("outputs not at their reset values after reset");
        violations++;
    end

    // the flag only drops after a clear write, or after reset
    assert property (@(posedge clk) disable iff (reset)
        $fell(ovSticky) |-> ($past(cfgWrite && cfgClearOv) || $past(reset))) else begin
        $error("ovSticky fell without a clear write");
        violations++;
    end

endmodule

bind execUnit execUnit_assertions assertI (
    .clk          (clk),
    .reset        (reset),
    .issue        (issue),
    .cfgWrite     (cfgWrite),
    .cfgClearOv   (cfgClearOv),
    .done         (done),
    .ov           (ov),
    .rotateEnable (rotateEnable),
    .ovSticky     (ovSticky)
);

/* verification/execUnit_tb.sv */
`include "exec_consts.svh"

module execUnit_tb;
    timeunit 1ns;
    timeprecision 1ps;

    // ==========================================================
    // run length
    // ==========================================================
    localparam int NUM_SHIFT    = 200;
    localparam int NUM_IMM      = 60;
    localparam int NUM_ALU      = 200;
    localparam int NUM_MIXED    = 100;
    // reset, the directed config and sticky checks, and the final drain
    localparam int NUM_DIRECTED = 56;
    // every driven cycle plus a margin of 50
    localparam int CYCLE_LIMIT  = NUM_SHIFT + NUM_IMM + NUM_ALU + NUM_MIXED + NUM_DIRECTED + 50;

    // function codes the random phases draw from
    localparam logic [4:0] SHIFT_CODES [6] = '{`SHL, `ASL, `SHR, `ASR, `ROL, `ROR};
    localparam logic [4:0] IMM_CODES [6]   = '{`SHLI, `ASLI, `SHRI, `ASRI, `ROLI, `RORI};
    localparam logic [4:0] ALU_CODES [5]   = '{`ADD, `SUB, `AND, `OR, `XOR};

    // one predicted retire slot, pushed for every driven cycle
    typedef struct packed {
        logic           valid;
        logic [`DMSB:0] res;
        logic           ov;
        logic [2:0]     testId;
    } expected_t;

    logic           clk;
    logic           reset;
    logic           issue;
    logic [39:0]    instr;
    logic [`DMSB:0] a;
    logic [`DMSB:0] b;
    logic           cfgWrite;
    logic           cfgRotateEnable;
    logic           cfgClearOv;
    logic           done;
    logic [`DMSB:0] res;
    logic           ov;
    logic           rotateEnable;
    logic           ovSticky;

    expected_t      pending[$];
    logic           modelRotate;
    logic [2:0]     testId;
    int             cycleCount = 0;

    execUnit execUnit_i (.*);

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        cycleCount = cycleCount + 1;
        if (cycleCount > CYCLE_LIMIT) begin
            $display("sim failed");
            $fatal(1, "timeout, the run went past %0d cycles", CYCLE_LIMIT);
        end
    end

    // ==========================================================
    // stimulus helpers
    // ==========================================================
    function automatic logic [`DMSB:0] randomWord();
        logic [31:0] w0;
        logic [31:0] w1;
        logic [31:0] w2;
        w0 = $urandom();
        w1 = $urandom();
        w2 = $urandom();
        return {w0, w1, w2[15:0]};
    endfunction

    // small sign extended values give shifts that do not overflow
    function automatic logic [`DMSB:0] randomOperand();
        logic [15:0] shortValue;
        shortValue = 16'($urandom());
        if ($urandom() % 3 == 0) return {{(`DMSB - 15){shortValue[15]}}, shortValue};
        return randomWord();
    endfunction

    // the edges 0 and 79 come up often, and so does anything past a full word
    function automatic logic [6:0] randomAmount();
        case ($urandom() % 8)
            0: return 7'd0;
            1: return 7'd79;
            2, 3: return 7'(80 + $urandom() % 48);
            default: return 7'($urandom() % 80);
        endcase
    endfunction

    function automatic logic [`DMSB:0] amountWord();
        logic [`DMSB:0] word;
        word = randomWord();
        word[6:0] = randomAmount();
        return word;
    endfunction

    function automatic logic [4:0] randomFunct();
        case ($urandom() % 3)
            0: return SHIFT_CODES[3'($urandom() % 6)];
            1: return IMM_CODES[3'($urandom() % 6)];
            default: return ALU_CODES[3'($urandom() % 5)];
        endcase
    endfunction

    // the bits outside the three fields carry noise that decode must ignore
    function automatic logic [39:0] makeInstr(logic [5:0] opcode, logic [4:0] funct,
                                              logic [6:0] amount);
        logic [39:0] word;
        word = 40'(randomWord());
        word[`OPCODE_FIELD] = opcode;
        word[`FUNCT_FIELD]  = funct;
        word[`AMOUNT_FIELD] = amount;
        return word;
    endfunction

    // ==========================================================
    // reference model, returns {ov, res}
    // ==========================================================
    function automatic logic [`DMSB+1:0] predict(logic [39:0] word, logic [`DMSB:0] x,
                                                 logic [`DMSB:0] y, logic rotOn);
        logic [4:0]     funct;
        logic [6:0]     amt;
        logic [`DMSB:0] r;
        logic [`DMSB:0] signs;
        logic [`DMSB:0] spill;
        logic [`DMSB+1:0] wide;
        logic           o;
        int             k;
        funct = word[`FUNCT_FIELD];
        amt   = (funct inside {`SHLI, `ASLI, `SHRI, `ASRI, `ROLI, `RORI}) ?
                word[`AMOUNT_FIELD] : y[6:0];
        k     = int'(amt);
        signs = {(`DMSB + 1){x[`DMSB]}};
        r     = '0;
        o     = 1'b0;
        if (word[`OPCODE_FIELD] != `OP_R1) return '0;
        case (funct)
            `SHL, `SHLI, `ASL, `ASLI: begin
                r = x << k;
                // the top k bits of x leave the word and each must equal the sign
                spill = (k >= `DMSB + 1) ? (x ^ signs) : ((x ^ signs) >> (`DMSB + 1 - k));
                o = (spill != '0);
            end
            `SHR, `SHRI: r = x >> k;
            `ASR, `ASRI: r = $signed(x) >>> k;
            `ROL, `ROLI, `ROR, `RORI: begin
                if (!rotOn) begin
                    r = `MARKER;
                end else if (k > `DMSB) begin
                    // past a full turn only the spill of the double width shift is left
                    r = (funct inside {`ROL, `ROLI}) ? (x << (k - 80)) : (x >> (k - 80));
                end else if (funct inside {`ROL, `ROLI}) begin
                    r = (x << k) | (x >> (`DMSB + 1 - k));
                end else begin
                    r = (x >> k) | (x << (`DMSB + 1 - k));
                end
            end
            // signed overflow shows as a disagreement of the two top bits of a
            // sign extended 81 bit sum
            `ADD, `SUB: begin
                wide = (funct == `ADD) ? ({x[`DMSB], x} + {y[`DMSB], y}) :
                                         ({x[`DMSB], x} - {y[`DMSB], y});
                r = wide[`DMSB:0];
                o = (wide[`DMSB+1] != wide[`DMSB]);
            end
            `AND: r = x & y;
            `OR:  r = x | y;
            `XOR: r = x ^ y;
            default: r = '0;
        endcase
        return {o, r};
    endfunction

    // ==========================================================
    // scoreboard and drive tasks
    // ==========================================================
    function automatic string testName(logic [2:0] id);
        case (id)
            3'd0: return "random shifts";
            3'd1: return "immediate shifts";
            3'd2: return "add and logic";
            3'd3: return "config and unknown ops";
            3'd4: return "sticky overflow";
            default: return "mixed stream";
        endcase
    endfunction

    task automatic reportValue(string test, string what, logic [`DMSB:0] expected,
                               logic [`DMSB:0] actual);
        $display("CHECK FAILED %s: %s expected %h actual %h", test, what, expected, actual);
        $display("sim failed");
    endtask

    // outputs settled half a cycle ago, so the falling edge is a safe place to look
    task automatic checkOldest();
        expected_t oldest;
        if (pending.size() == 2) begin
            oldest = pending.pop_front();
            assert (done == oldest.valid) else begin
                reportValue(testName(oldest.testId), "done", {{`DMSB{1'b0}}, oldest.valid},
                            {{`DMSB{1'b0}}, done});
                $fatal(1, "done out of step with issue");
            end
            if (oldest.valid) begin
                assert (res == oldest.res) else begin
                    reportValue(testName(oldest.testId), "res", oldest.res, res);
                    $fatal(1, "result mismatch");
                end
                assert (ov == oldest.ov) else begin
                    reportValue(testName(oldest.testId), "ov", {{`DMSB{1'b0}}, oldest.ov},
                                {{`DMSB{1'b0}}, ov});
                    $fatal(1, "overflow mismatch");
                end
            end
        end
    endtask

    task automatic checkStatus(string what, logic expected, logic actual);
        assert (actual == expected) else begin
            reportValue(testName(testId), what, {{`DMSB{1'b0}}, expected},
                        {{`DMSB{1'b0}}, actual});
            $fatal(1, "%s has the wrong value", what);
        end
    endtask

    task automatic advance();
        @(negedge clk);
        checkOldest();
        issue           = 1'b0;
        cfgWrite        = 1'b0;
        cfgClearOv      = 1'b0;
        cfgRotateEnable = modelRotate;
    endtask

    task automatic issueOp(logic [39:0] word, logic [`DMSB:0] x, logic [`DMSB:0] y);
        expected_t        slot;
        logic [`DMSB+1:0] prediction;
        advance();
        issue = 1'b1;
        instr = word;
        a     = x;
        b     = y;
        prediction  = predict(word, x, y, modelRotate);
        slot.valid  = 1'b1;
        slot.res    = prediction[`DMSB:0];
        slot.ov     = prediction[`DMSB+1];
        slot.testId = testId;
        pending.push_back(slot);
    endtask

    task automatic idleCycle();
        expected_t slot;
        advance();
        // operands keep moving while issue is low
        a = randomWord();
        slot = '0;
        slot.testId = testId;
        pending.push_back(slot);
    endtask

    // written while nothing issues, so the new enable only reaches later issues
    task automatic writeConfig(logic rotOn, logic clearOv);
        expected_t slot;
        advance();
        cfgWrite        = 1'b1;
        cfgRotateEnable = rotOn;
        cfgClearOv      = clearOv;
        modelRotate     = rotOn;
        slot = '0;
        slot.testId = testId;
        pending.push_back(slot);
    endtask

    // ==========================================================
    // test sequence
    // ==========================================================
    initial begin
        void'($urandom(30));
        reset           = 1'b1;
        issue           = 1'b0;
        instr           = '0;
        a               = '0;
        b               = '0;
        cfgWrite        = 1'b0;
        cfgRotateEnable = 1'b1;
        cfgClearOv      = 1'b0;
        modelRotate     = 1'b1;
        testId          = 3'd0;
        repeat (3) @(posedge clk);
        @(negedge clk);
        reset = 1'b0;

        // shifts by b, one issue every cycle
        repeat (NUM_SHIFT) begin
            issueOp(makeInstr(`OP_R1, SHIFT_CODES[3'($urandom() % 6)], 7'($urandom())),
                    randomOperand(), amountWord());
        end
        // immediate forms, b is pure noise here
        testId = 3'd1;
        repeat (NUM_IMM) begin
            issueOp(makeInstr(`OP_R1, IMM_CODES[3'($urandom() % 6)], randomAmount()),
                    randomOperand(), randomWord());
        end
        testId = 3'd2;
        repeat (NUM_ALU) begin
            issueOp(makeInstr(`OP_R1, ALU_CODES[3'($urandom() % 5)], 7'($urandom())),
                    randomWord(), randomWord());
        end

        // rotates switched off give the marker, unknown codes give zero
        testId = 3'd3;
        writeConfig(1'b0, 1'b0);
        idleCycle();
        checkStatus("rotateEnable", 1'b0, rotateEnable);
        repeat (20) begin
            issueOp(makeInstr(`OP_R1, ($urandom() % 2 == 0) ? `ROL : `RORI, randomAmount()),
                    randomWord(), amountWord());
        end
        repeat (5) begin
            issueOp(makeInstr(`OP_R1 ^ 6'(1 + $urandom() % 63), randomFunct(), randomAmount()),
                    randomWord(), amountWord());
        end
        repeat (5) begin
            issueOp(makeInstr(`OP_R1, 5'(5'h15 + $urandom() % 11), randomAmount()),
                    randomWord(), randomWord());
        end
        writeConfig(1'b1, 1'b0);

        // the flag rises one cycle after the overflowing result retires
        testId = 3'd4;
        repeat (3) idleCycle();
        writeConfig(1'b1, 1'b1);
        idleCycle();
        checkStatus("ovSticky", 1'b0, ovSticky);
        issueOp(makeInstr(`OP_R1, `ADD, 7'd0), {1'b0, {`DMSB{1'b1}}}, {{`DMSB{1'b0}}, 1'b1});
        repeat (3) idleCycle();
        checkStatus("ovSticky", 1'b1, ovSticky);
        writeConfig(1'b1, 1'b1);
        idleCycle();
        checkStatus("ovSticky", 1'b0, ovSticky);

        // everything at once, with gaps and rotate enable changes in the stream
        testId = 3'd5;
        repeat (NUM_MIXED) begin
            case ($urandom() % 16)
                0: writeConfig(1'($urandom()), 1'($urandom()));
                1, 2: idleCycle();
                3: issueOp(makeInstr(6'($urandom()), randomFunct(), randomAmount()),
                           randomOperand(), amountWord());
                default: issueOp(makeInstr(`OP_R1, randomFunct(), randomAmount()),
                                 randomOperand(), amountWord());
            endcase
        end
        repeat (2) idleCycle();

        if (execUnit_i.assertI.violations == 0) begin
            $display("sim passed");
            $finish;
        end else begin
            $display("sim failed");
            $fatal(1, "%0d concurrent assertion failures", execUnit_i.assertI.violations);
        end
    end

endmodule

/* flist.f */
+incdir+source
source/execPkg.sv
source/instrDecode.sv
source/shifter.sv
source/addLogicUnit.sv
source/execConfig.sv
source/pipeStage.sv
source/execUnit.sv
verification/execUnit_assertions.sv
verification/execUnit_tb.sv

/* run.sh */
#!/bin/sh
# build the testbench with Verilator, run it, then look for the pass line in the log
rm -f build.log sim.log
verilator --binary --timing --assert -f flist.f --top-module execUnit_tb -o simv \
    > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }
./obj_dir/simv > sim.log 2>&1 || echo "simulator returned an error status"
grep -qx "sim passed" sim.log && echo "PASS" || { echo "FAIL, see sim.log"; exit 1; }
